/* all.f */
common/cpu_pkg.sv
cpu/alu.sv
cpu/reg_file.sv
cpu/cpu_control.sv
design/pin_bus_bridge.sv
design/cpu_bus_top.sv
testbench/pin_memory_model.sv
testbench/cpu_bus_tb.sv

/* common/cpu_pkg.sv */
// CPU shared definitions
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [2:0]  reg_idx_t;
  typedef logic [15:0] imm_t;
  typedef logic [7:0]  bus_byte_t;
  typedef logic [3:0]  phase_t;

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_ADDI = 4'd5,
    OP_LUI  = 4'd6,
    OP_LW   = 4'd7,
    OP_SW   = 4'd8,
    OP_BEQ  = 4'd9,
    OP_HALT = 4'd15
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_e;

  typedef enum logic [2:0] {
    ST_FETCH = 3'd0,
    ST_EXEC  = 3'd1,
    ST_MEM   = 3'd2,
    ST_WB    = 3'd3,
    ST_HALT  = 3'd4
  } cpu_state_e;

  localparam int    NUM_REGS = 8;
  localparam word_t RESET_PC = 32'h0000_0000;

  // Pin bus phases
  localparam phase_t PH_IDLE       = 4'd0;
  localparam phase_t PH_ADDR_FIRST = 4'd1;   // Also the frame phase
  localparam phase_t PH_ADDR_LAST  = 4'd4;
  localparam phase_t PH_CMD        = 4'd5;
  localparam phase_t PH_RD_FIRST   = 4'd6;
  localparam phase_t PH_RD_LAST    = 4'd9;
  localparam phase_t BUS_PHASES    = 4'd10;  // Ack phase

endpackage

/* cpu/alu.sv */
// Arithmetic logic unit
`timescale 1ns/1ps

module alu
  import cpu_pkg::*;
(
  input  alu_op_e alu_op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result,
  output logic    equal
);

  always_comb begin
    case (alu_op)
      ALU_ADD: result = a + b;   // Wraps at 32 bits
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      default: result = a + b;
    endcase
  end

  assign equal = (a == b);  // Branch compare

endmodule

/* cpu/cpu_control.sv */
// CPU control and bus master
`timescale 1ns/1ps

module cpu_control
  import cpu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     run,
  input  word_t    wb_dat_r,
  input  logic     wb_ack,
  input  word_t    rd1,
  input  word_t    rd2,
  input  word_t    alu_result,
  input  logic     alu_equal,
  output logic     wb_cyc,
  output logic     wb_stb,
  output logic     wb_we,
  output word_t    wb_adr,
  output word_t    wb_dat_w,
  output reg_idx_t rs1_sel,
  output reg_idx_t rs2_sel,
  output reg_idx_t rd_sel,
  output logic     reg_wr_en,
  output word_t    reg_wr_data,
  output alu_op_e  alu_op,
  output word_t    alu_b,
  output logic     halted
);

  cpu_state_e state;
  word_t      pc;
  word_t      ir;
  word_t      load_q;
  logic       fetch_busy;   // Fetch request in flight

  opcode_e    opcode;
  imm_t       imm;
  word_t      imm_sext;
  word_t      pc_next;
  word_t      branch_target;
  logic       b_from_reg;
  logic       writes_rd;

  assign opcode        = opcode_e'(ir[31:28]);
  assign imm           = ir[15:0];
  assign imm_sext      = {{16{imm[15]}}, imm};
  assign pc_next       = pc + 32'd4;
  assign branch_target = pc_next + {imm_sext[29:0], 2'b00};  // Word offset

  assign rd_sel  = ir[27:25];
  assign rs1_sel = ir[24:22];
  assign rs2_sel = ir[21:19];

  assign b_from_reg = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_BEQ};
  assign writes_rd  = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                     OP_ADDI, OP_LUI, OP_LW};

  always_comb begin
    case (opcode)
      OP_SUB:  alu_op = ALU_SUB;
      OP_AND:  alu_op = ALU_AND;
      OP_OR:   alu_op = ALU_OR;
      OP_XOR:  alu_op = ALU_XOR;
      OP_BEQ:  alu_op = ALU_SUB;
      default: alu_op = ALU_ADD;  // ADDI and address calculation
    endcase
  end

  assign alu_b = b_from_reg ? rd2 : imm_sext;

  // Write-back source
  always_comb begin
    case (opcode)
      OP_LUI:  reg_wr_data = {imm, 16'h0000};
      OP_LW:   reg_wr_data = load_q;
      default: reg_wr_data = alu_result;
    endcase
  end

  assign reg_wr_en = (state == ST_WB) && writes_rd;

  // Held until ack even if run drops mid fetch
  assign wb_stb   = ((state == ST_FETCH) && (run || fetch_busy)) || (state == ST_MEM);
  assign wb_cyc   = wb_stb;
  assign wb_we    = (state == ST_MEM) && (opcode == OP_SW);
  assign wb_adr   = (state == ST_MEM) ? alu_result : pc;
  assign wb_dat_w = rd2;
  assign halted   = (state == ST_HALT);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_FETCH;
      pc         <= RESET_PC;
      ir         <= '0;
      fetch_busy <= 1'b0;
    end else begin
      fetch_busy <= (state == ST_FETCH) && wb_stb && !wb_ack;
      case (state)
        ST_FETCH: begin
          if (wb_ack) begin
            ir    <= wb_dat_r;
            state <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          case (opcode)
            OP_HALT: state <= ST_HALT;
            OP_BEQ: begin
              pc    <= alu_equal ? branch_target : pc_next;
              state <= ST_FETCH;
            end
            OP_LW, OP_SW: begin
              pc    <= pc_next;
              state <= ST_MEM;
            end
            default: begin
              pc    <= pc_next;
              state <= writes_rd ? ST_WB : ST_FETCH;  // Unknown opcodes skip
            end
          endcase
        end
        ST_MEM: begin
          if (wb_ack) begin
            state <= (opcode == OP_LW) ? ST_WB : ST_FETCH;
          end
        end
        ST_WB:   state <= ST_FETCH;
        ST_HALT: state <= ST_HALT;
        default: state <= ST_FETCH;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == ST_MEM) && wb_ack) begin
      load_q <= wb_dat_r;
    end
  end

  // A request stays up until the slave answers
  assert property (@(posedge clk) disable iff (rst)
    (wb_stb && !wb_ack) |=> wb_stb)
    else $error("wb_stb dropped before wb_ack");

  // Stores and branches never reach the write-back step
  assert property (@(posedge clk) disable iff (rst)
    (state == ST_WB) |-> ($past(state) inside {ST_EXEC, ST_MEM}) &&
                         !(opcode inside {OP_SW, OP_BEQ}))
    else $error("store or branch reached write-back");

endmodule

/* cpu/reg_file.sv */
// Register file
`timescale 1ns/1ps

module reg_file
  import cpu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1_sel,
  input  reg_idx_t rs2_sel,
  input  reg_idx_t rd_sel,
  input  logic     wr_en,
  input  word_t    wr_data,
  output word_t    rd1,
  output word_t    rd2
);

  word_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '{default: '0};
    end else if (wr_en && (rd_sel != '0)) begin
      regs[rd_sel] <= wr_data;
    end
  end

  // Register zero is hardwired
  assign rd1 = (rs1_sel == '0) ? '0 : regs[rs1_sel];
  assign rd2 = (rs2_sel == '0) ? '0 : regs[rs2_sel];

endmodule

/* design/cpu_bus_top.sv */
// CPU with pin bus top level
`timescale 1ns/1ps

module cpu_bus_top
  import cpu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      run,
  input  bus_byte_t uio_in,
  output bus_byte_t uo_out,
  output bus_byte_t uio_out,
  output bus_byte_t uio_oe,
  output logic      frame,
  output logic      halted
);

  logic     wb_cyc;
  logic     wb_stb;
  logic     wb_we;
  word_t    wb_adr;
  word_t    wb_dat_w;
  word_t    wb_dat_r;
  logic     wb_ack;

  reg_idx_t rs1_sel;
  reg_idx_t rs2_sel;
  reg_idx_t rd_sel;
  logic     reg_wr_en;
  word_t    reg_wr_data;
  word_t    rd1;
  word_t    rd2;

  alu_op_e  alu_op;
  word_t    alu_b;
  word_t    alu_result;
  logic     alu_equal;

  cpu_control cpu_control_inst (
    .clk         (clk),
    .rst         (rst),
    .run         (run),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .rd1         (rd1),
    .rd2         (rd2),
    .alu_result  (alu_result),
    .alu_equal   (alu_equal),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .rs1_sel     (rs1_sel),
    .rs2_sel     (rs2_sel),
    .rd_sel      (rd_sel),
    .reg_wr_en   (reg_wr_en),
    .reg_wr_data (reg_wr_data),
    .alu_op      (alu_op),
    .alu_b       (alu_b),
    .halted      (halted)
  );

  reg_file reg_file_inst (
    .clk     (clk),
    .rst     (rst),
    .rs1_sel (rs1_sel),
    .rs2_sel (rs2_sel),
    .rd_sel  (rd_sel),
    .wr_en   (reg_wr_en),
    .wr_data (reg_wr_data),
    .rd1     (rd1),
    .rd2     (rd2)
  );

  // Operand a is always rs1
  alu alu_inst (
    .alu_op (alu_op),
    .a      (rd1),
    .b      (alu_b),
    .result (alu_result),
    .equal  (alu_equal)
  );

  pin_bus_bridge pin_bus_bridge_inst (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .uio_in   (uio_in),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .uo_out   (uo_out),
    .uio_out  (uio_out),
    .uio_oe   (uio_oe),
    .frame    (frame)
  );

endmodule

/* design/pin_bus_bridge.sv */
// Wishbone to pin bus bridge
`timescale 1ns/1ps

module pin_bus_bridge
  import cpu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      wb_cyc,
  input  logic      wb_stb,
  input  logic      wb_we,
  input  word_t     wb_adr,
  input  word_t     wb_dat_w,
  input  bus_byte_t uio_in,
  output word_t     wb_dat_r,
  output logic      wb_ack,
  output bus_byte_t uo_out,
  output bus_byte_t uio_out,
  output bus_byte_t uio_oe,
  output logic      frame
);

  phase_t     phase;
  word_t      adr_q;
  word_t      dat_q;
  word_t      rdata_q;
  logic       we_q;
  logic [1:0] wr_idx;
  logic [1:0] rd_idx;
  logic       start;

  assign start  = (phase == PH_IDLE) && wb_cyc && wb_stb;
  assign wr_idx = 2'(phase - PH_ADDR_FIRST);  // Byte lane, LSB first
  assign rd_idx = 2'(phase - PH_RD_FIRST);

  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= PH_IDLE;
    end else if (phase == PH_IDLE) begin
      if (start) begin
        phase <= PH_ADDR_FIRST;
      end
    end else if (phase == BUS_PHASES) begin
      phase <= PH_IDLE;
    end else begin
      phase <= phase + 4'd1;
    end
  end

  // Stable copy of the request for the pin phases
  always_ff @(posedge clk) begin
    if (start) begin
      adr_q <= wb_adr;
      dat_q <= wb_dat_w;
      we_q  <= wb_we;
    end
    if ((phase >= PH_RD_FIRST) && (phase <= PH_RD_LAST)) begin
      rdata_q[8*rd_idx +: 8] <= uio_in;
    end
  end

  always_comb begin
    uo_out  = '0;
    uio_out = '0;
    if ((phase >= PH_ADDR_FIRST) && (phase <= PH_ADDR_LAST)) begin
      uo_out  = adr_q[8*wr_idx +: 8];
      uio_out = dat_q[8*wr_idx +: 8];
    end else if (phase == PH_CMD) begin
      uo_out = {7'b0000000, we_q};  // Command byte, bit 0 is write
    end
  end

  assign uio_oe   = ((phase != PH_IDLE) && we_q) ? 8'hff : 8'h00;
  assign frame    = (phase == PH_ADDR_FIRST);
  assign wb_ack   = (phase == BUS_PHASES);
  assign wb_dat_r = rdata_q;

  assert property (@(posedge clk) disable iff (rst)
    wb_ack |=> !wb_ack)
    else $error("wb_ack longer than one cycle");

  // Pin direction is fixed for the whole frame
  assert property (@(posedge clk) disable iff (rst)
    (phase > PH_ADDR_FIRST) |-> $stable(uio_oe))
    else $error("uio_oe changed inside a frame");

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module cpu_bus_tb -f all.f -o cpu_bus_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/cpu_bus_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi
exit 0

/* testbench/cpu_bus_tb.sv */
// CPU pin bus testbench
`timescale 1ns/1ps

module cpu_bus_tb
  import cpu_pkg::*;
();

  localparam int HALT_TIMEOUT = 20000;
  localparam int IDLE_CYCLES  = 50;
  localparam int QUIET_CYCLES = 100;

  logic      clk;
  logic      rst;
  logic      run;
  bus_byte_t uio_in;
  bus_byte_t uo_out;
  bus_byte_t uio_out;
  bus_byte_t uio_oe;
  logic      frame;
  logic      halted;

  string     test_name;
  int        test_errors;
  int        tests_run;
  int        tests_failed;
  int        total_errors;
  int        stores_in_program;
  word_t     program_words[$];
  word_t     expected_words[$];

  cpu_bus_top cpu_bus_top_inst (
    .clk     (clk),
    .rst     (rst),
    .run     (run),
    .uio_in  (uio_in),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .frame   (frame),
    .halted  (halted)
  );

  pin_memory_model mem_model (
    .clk     (clk),
    .rst     (rst),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .frame   (frame),
    .uio_in  (uio_in)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic word_t encode(opcode_e op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
                                   imm_t imm);
    return {op, rd, rs1, rs2, 3'b000, imm};
  endfunction

  function automatic word_t sign_extend(imm_t imm);
    return {{16{imm[15]}}, imm};
  endfunction

  // LUI half that gives v after an ADDI of the low half
  function automatic imm_t upper_half(word_t v);
    return v[31:16] + {15'd0, v[15]};
  endfunction

  task automatic report_mismatch(string what, word_t expected, word_t actual);
    $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
    test_errors++;
  endtask

  task automatic report_problem(string what);
    $display("Test %s: %s", test_name, what);
    test_errors++;
  endtask

  task automatic begin_test(string name);
    test_name   = name;
    test_errors = 0;
    @(negedge clk);
    rst = 1'b1;
    run = 1'b0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    mem_model.fill_memory();
  endtask

  task automatic end_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("Test %s passed", test_name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", test_name, test_errors);
    end
  endtask

  task automatic load_program();
    stores_in_program = 0;
    foreach (program_words[i]) begin
      mem_model.write_word(32'(i * 4), program_words[i]);
      if (program_words[i][31:28] == OP_SW) begin
        stores_in_program++;
      end
    end
    program_words.delete();
  endtask

  task automatic run_to_halt();
    int cycles;
    cycles = 0;
    run    = 1'b1;
    while (!halted && (cycles < HALT_TIMEOUT)) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      report_problem($sformatf("CPU did not halt within %0d cycles", HALT_TIMEOUT));
    end
  endtask

  // Register operation on r1 and r2, result stored at addr
  task automatic add_reg_op(opcode_e op, word_t a, word_t b, imm_t addr);
    program_words.push_back(encode(op, 3'd3, 3'd1, 3'd2, 16'h0000));
    program_words.push_back(encode(OP_SW, 3'd0, 3'd0, 3'd3, addr));
    case (op)
      OP_SUB:  expected_words.push_back(a - b);
      OP_AND:  expected_words.push_back(a & b);
      OP_OR:   expected_words.push_back(a | b);
      OP_XOR:  expected_words.push_back(a ^ b);
      default: expected_words.push_back(a + b);
    endcase
  endtask

  task automatic test_idle_after_reset();
    begin_test("idle_after_reset");
    for (int i = 0; i < IDLE_CYCLES; i++) begin
      @(negedge clk);
      if (frame !== 1'b0) report_problem($sformatf("frame pulse at cycle %0d with run low", i));
      if (uio_oe !== 8'h00) report_mismatch("uio_oe", 32'h0, 32'(uio_oe));
      if (halted !== 1'b0) report_problem("halted is high after reset");
    end
    end_test();
  endtask

  task automatic test_alu_ops();
    word_t a;
    word_t b;
    word_t c;
    word_t d;
    word_t got;
    begin_test("alu_ops");
    expected_words.delete();
    a = $urandom();
    b = $urandom();
    c = $urandom();
    d = $urandom();
    program_words.push_back(encode(OP_LUI, 3'd1, 3'd0, 3'd0, upper_half(a)));
    program_words.push_back(encode(OP_ADDI, 3'd1, 3'd1, 3'd0, a[15:0]));
    program_words.push_back(encode(OP_LUI, 3'd2, 3'd0, 3'd0, upper_half(b)));
    program_words.push_back(encode(OP_ADDI, 3'd2, 3'd2, 3'd0, b[15:0]));
    add_reg_op(OP_ADD, a, b, 16'h0100);
    add_reg_op(OP_SUB, a, b, 16'h0104);
    add_reg_op(OP_AND, a, b, 16'h0108);
    add_reg_op(OP_OR, a, b, 16'h010c);
    add_reg_op(OP_XOR, a, b, 16'h0110);
    program_words.push_back(encode(OP_ADDI, 3'd4, 3'd1, 3'd0, d[15:0]));
    program_words.push_back(encode(OP_SW, 3'd0, 3'd0, 3'd4, 16'h0114));
    expected_words.push_back(a + sign_extend(d[15:0]));
    program_words.push_back(encode(OP_LUI, 3'd5, 3'd0, 3'd0, c[15:0]));
    program_words.push_back(encode(OP_SW, 3'd0, 3'd0, 3'd5, 16'h0118));
    expected_words.push_back({c[15:0], 16'h0000});
    program_words.push_back(encode(OP_HALT, 3'd0, 3'd0, 3'd0, 16'h0000));
    load_program();
    run_to_halt();
    foreach (expected_words[k]) begin
      got = mem_model.read_word(32'h100 + 32'(4 * k));
      if (got !== expected_words[k]) begin
        report_mismatch($sformatf("word %0d", k), expected_words[k], got);
      end
    end
    end_test();
  endtask

  task automatic test_load_store();
    word_t words[$];
    word_t sum;
    word_t got;
    begin_test("load_store");
    sum = '0;
    for (int k = 0; k < 3; k++) begin
      words.push_back($urandom());
      mem_model.write_word(32'h180 + 32'(4 * k), words[k]);
      sum += words[k];
      program_words.push_back(encode(OP_LW, 3'(k + 1), 3'd0, 3'd0, 16'(384 + 4 * k)));
    end
    program_words.push_back(encode(OP_ADD, 3'd4, 3'd1, 3'd2, 16'h0000));
    program_words.push_back(encode(OP_ADD, 3'd4, 3'd4, 3'd3, 16'h0000));
    program_words.push_back(encode(OP_SW, 3'd0, 3'd0, 3'd4, 16'h0190));
    program_words.push_back(encode(OP_HALT, 3'd0, 3'd0, 3'd0, 16'h0000));
    load_program();
    run_to_halt();
    got = mem_model.read_word(32'h190);
    if (got !== sum) report_mismatch("sum", sum, got);
    foreach (words[k]) begin
      got = mem_model.read_word(32'h180 + 32'(4 * k));
      if (got !== words[k]) report_mismatch($sformatf("preload %0d", k), words[k], got);
    end
    end_test();
  endtask

  task automatic test_branch_loop();
    int unsigned count;
    imm_t        step;
    word_t       acc;
    word_t       got;
    begin_test("branch_loop");
    count = 1 + ($urandom() % 9);
    step  = 16'($urandom());
    acc   = '0;
    for (int unsigned i = 0; i < count; i++) begin
      acc += sign_extend(step);
    end
    program_words.push_back(encode(OP_ADDI, 3'd1, 3'd0, 3'd0, 16'(count)));
    program_words.push_back(encode(OP_ADDI, 3'd2, 3'd0, 3'd0, 16'h0000));
    program_words.push_back(encode(OP_ADDI, 3'd3, 3'd0, 3'd0, 16'h0000));
    program_words.push_back(encode(OP_ADDI, 3'd2, 3'd2, 3'd0, 16'h0001));  // Loop top
    program_words.push_back(encode(OP_ADDI, 3'd3, 3'd3, 3'd0, step));
    program_words.push_back(encode(OP_ADDI, 3'd1, 3'd1, 3'd0, 16'hffff));
    program_words.push_back(encode(OP_BEQ, 3'd0, 3'd1, 3'd0, 16'h0001));   // Exit at zero
    program_words.push_back(encode(OP_BEQ, 3'd0, 3'd0, 3'd0, 16'hfffb));   // Back to loop top
    program_words.push_back(encode(OP_SW, 3'd0, 3'd0, 3'd3, 16'h01c0));
    program_words.push_back(encode(OP_SW, 3'd0, 3'd0, 3'd2, 16'h01c4));
    program_words.push_back(encode(OP_HALT, 3'd0, 3'd0, 3'd0, 16'h0000));
    load_program();
    run_to_halt();
    got = mem_model.read_word(32'h1c0);
    if (got !== acc) report_mismatch("accumulated value", acc, got);
    got = mem_model.read_word(32'h1c4);
    if (got !== 32'(count)) report_mismatch("iteration count", 32'(count), got);
    end_test();
  endtask

  task automatic test_pin_direction();
    word_t value;
    word_t got;
    begin_test("pin_direction");
    value = $urandom();
    mem_model.write_word(32'h140, value);
    program_words.push_back(encode(OP_LW, 3'd1, 3'd0, 3'd0, 16'h0140));
    program_words.push_back(encode(OP_SW, 3'd0, 3'd0, 3'd1, 16'h0144));
    program_words.push_back(encode(OP_LW, 3'd2, 3'd0, 3'd0, 16'h0144));
    program_words.push_back(encode(OP_SW, 3'd0, 3'd0, 3'd2, 16'h0148));
    program_words.push_back(encode(OP_HALT, 3'd0, 3'd0, 3'd0, 16'h0000));
    load_program();
    run_to_halt();
    if (mem_model.dir_errors != 0) begin
      report_problem($sformatf("%0d frames had uio_oe against the command bit",
                               mem_model.dir_errors));
    end
    if (mem_model.cmd_errors != 0) begin
      report_problem($sformatf("%0d command bytes had bits set other than bit 0",
                               mem_model.cmd_errors));
    end
    if (mem_model.read_frames != 7) begin
      report_mismatch("read frames", 32'd7, mem_model.read_frames);
    end
    if (mem_model.write_frames != 2) begin
      report_mismatch("write frames", 32'd2, mem_model.write_frames);
    end
    got = mem_model.read_word(32'h148);
    if (got !== value) report_mismatch("copied word", value, got);
    end_test();
  endtask

  task automatic test_halt_quiet();
    imm_t  value;
    word_t got;
    int    pulses;
    begin_test("halt_quiet");
    value = 16'($urandom());
    program_words.push_back(encode(OP_ADDI, 3'd1, 3'd0, 3'd0, value));
    program_words.push_back(encode(OP_SW, 3'd0, 3'd0, 3'd1, 16'h01e0));
    program_words.push_back(encode(OP_SW, 3'd0, 3'd0, 3'd1, 16'h01e4));
    program_words.push_back(encode(OP_SW, 3'd0, 3'd0, 3'd1, 16'h01e8));
    program_words.push_back(encode(OP_HALT, 3'd0, 3'd0, 3'd0, 16'h0000));
    load_program();
    run_to_halt();
    pulses = 0;
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(negedge clk);
      if (frame) pulses++;
      if (!halted) report_problem($sformatf("halted dropped %0d cycles after halt", i));
    end
    if (pulses != 0) report_problem($sformatf("%0d frame pulses after halt", pulses));
    if (mem_model.write_frames != stores_in_program) begin
      report_mismatch("store frames", 32'(stores_in_program), mem_model.write_frames);
    end
    for (int k = 0; k < 3; k++) begin
      got = mem_model.read_word(32'h1e0 + 32'(4 * k));
      if (got !== sign_extend(value)) begin
        report_mismatch($sformatf("word %0d", k), sign_extend(value), got);
      end
    end
    end_test();
  endtask

  initial begin
    rst          = 1'b1;
    run          = 1'b0;
    tests_run    = 0;
    tests_failed = 0;
    total_errors = 0;
    void'($urandom(32'h52272a0c));
    test_idle_after_reset();
    test_alu_ops();
    test_load_store();
    test_branch_loop();
    test_halt_quiet();
    test_pin_direction();  // Last, so its direction count covers every frame of the run
    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, total_errors);
    if (tests_failed == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* testbench/pin_memory_model.sv */
// Pin bus word memory
`timescale 1ns/1ps

module pin_memory_model
  import cpu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  bus_byte_t uo_out,
  input  bus_byte_t uio_out,
  input  bus_byte_t uio_oe,
  input  logic      frame,
  output bus_byte_t uio_in
);

  word_t       mem [256];
  phase_t      ph;
  word_t       adr_sh;        // Address bytes arrive LSB first
  word_t       wdat_sh;
  word_t       rdat_sh;
  logic        is_write;
  logic        oe_ones;
  logic        oe_zero;
  int unsigned read_frames;
  int unsigned write_frames;
  int unsigned dir_errors;    // Kept across resets
  int unsigned cmd_errors;    // Also kept across resets

  initial begin
    ph           = PH_IDLE;
    uio_in       = '0;
    read_frames  = 0;
    write_frames = 0;
    dir_errors   = 0;
    cmd_errors   = 0;
  end

  task automatic fill_memory();
    for (int i = 0; i < 256; i++) begin
      mem[8'(i)] = 32'hc0de_0000 ^ 32'(i * 4);  // Byte address in the low bits
    end
  endtask

  task automatic write_word(word_t addr, word_t data);
    mem[addr[9:2]] = data;
  endtask

  function automatic word_t read_word(word_t addr);
    return mem[addr[9:2]];
  endfunction

  // Follows the bridge phases, sampling and driving mid cycle
  always @(negedge clk) begin
    if (rst) begin
      ph           = PH_IDLE;
      uio_in       = '0;
      read_frames  = 0;
      write_frames = 0;
    end else begin
      if (frame) begin
        ph      = PH_ADDR_FIRST;
        oe_ones = 1'b1;
        oe_zero = 1'b1;
      end else if (ph != PH_IDLE) begin
        ph = ph + 4'd1;
      end
      if (ph != PH_IDLE) begin
        oe_ones = oe_ones && (uio_oe == 8'hff);
        oe_zero = oe_zero && (uio_oe == 8'h00);
      end
      uio_in = '0;
      if ((ph >= PH_ADDR_FIRST) && (ph <= PH_ADDR_LAST)) begin
        adr_sh  = {uo_out, adr_sh[31:8]};
        wdat_sh = {uio_out, wdat_sh[31:8]};
      end else if (ph == PH_CMD) begin
        is_write = uo_out[0];
        if (uo_out[7:1] != '0) begin
          cmd_errors++;
        end
        if (is_write) begin
          mem[adr_sh[9:2]] = wdat_sh;
          write_frames++;
        end else begin
          rdat_sh = mem[adr_sh[9:2]];
          read_frames++;
        end
      end else if ((ph >= PH_RD_FIRST) && (ph <= PH_RD_LAST)) begin
        if (!is_write) begin
          uio_in  = rdat_sh[7:0];  // Sampled by the bridge on the next rising edge
          rdat_sh = rdat_sh >> 8;
        end
      end else if (ph == BUS_PHASES) begin
        if (is_write ? !oe_ones : !oe_zero) begin
          dir_errors++;
        end
        ph = PH_IDLE;
      end
    end
  end

endmodule
